// ==== include/mips_cp0_config.svh ====
`ifndef MIPS_CP0_CONFIG_SVH
`define MIPS_CP0_CONFIG_SVH

// cp0 register numbers
`define CP0_REG_COUNT       5'd9
`define CP0_REG_COMPARE     5'd11
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14
`define CP0_REG_PRID        5'd15
`define CP0_REG_CONFIG      5'd16

// exccode values in priority order from the highest
`define CODE_INT            5'd0
`define CODE_RI             5'd10
`define CODE_OVF            5'd12
`define CODE_TRAP           5'd13
`define CODE_SYS            5'd8

// exception vectors
`define EXC_VECTOR_NORMAL   32'h8000_0180
`define EXC_VECTOR_BOOT     32'hbfc0_0380

// fixed read values with BE (bit 15) set in config
`define PRID_VALUE          32'h0000_4200
`define CONFIG_VALUE        32'h0000_8000

// software writable bits
`define STATUS_WMASK        32'h0a60_ff01 // rp, re, bev, ts, im, ie
`define CAUSE_WMASK         32'h00c0_0300 // iv, wp, sw ip

`define CP0_RESET_WORD      32'h0000_0000

`endif

// ==== logic/cp0_pkg.sv ====
package cp0_pkg;

    //////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////

    typedef logic [31:0] cp0_word_t; // data or address word
    typedef logic [4:0]  cp0_addr_t; // cp0 register number
    typedef logic [4:0]  exc_code_t; // cause.exccode

    //////////////////////////////////////////////////
    // pipeline to cp0
    //////////////////////////////////////////////////

    // mtc0 request
    typedef struct packed {
        logic      we;
        cp0_addr_t addr;
        cp0_word_t data;
    } cp0_wr_t;

    // flags of the instruction at commit
    typedef struct packed {
        logic      valid;
        logic      syscall;
        logic      illegal;       // reserved instruction
        logic      trap;
        logic      overflow;
        logic      eret;
        logic      in_delay_slot;
        cp0_word_t pc;
    } exc_req_t;

    //////////////////////////////////////////////////
    // exception unit outputs
    //////////////////////////////////////////////////

    // what the register file records on the next edge
    typedef struct packed {
        logic      take;  // exception taken
        logic      eret;  // leave exception level
        exc_code_t code;
        logic      bd;    // branch delay flag
        cp0_word_t pc;    // already corrected for delay slot
    } exc_commit_t;

    // flush and new fetch address
    typedef struct packed {
        logic      flush;
        cp0_word_t target;
    } redirect_t;

endpackage

// ==== logic/cp0_regs.sv ====
`timescale 1ns/1ns

`include "mips_cp0_config.svh"

module cp0_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cp0_pkg::cp0_wr_t      wr,
    input  cp0_pkg::cp0_addr_t    rd_addr,
    output cp0_pkg::cp0_word_t    rd_data,
    input  logic [5:0]            hw_int,
    input  cp0_pkg::exc_commit_t  commit,
    output cp0_pkg::cp0_word_t    status,
    output cp0_pkg::cp0_word_t    cause,
    output cp0_pkg::cp0_word_t    epc,
    output logic                  timer_int
);
    import cp0_pkg::*;

    cp0_word_t count;     // r9
    cp0_word_t compare;   // r11
    cp0_word_t status_sw; // only status writable bits live here
    logic      exl;       // status[1]
    cp0_word_t cause_sw;  // only cause writable bits live here
    logic [5:0] hw_ip;    // cause[15:10]
    logic      bd;        // cause[31]
    exc_code_t exc_code;  // cause[6:2]

    logic wr_count;
    logic wr_compare;
    logic wr_status;
    logic wr_cause;
    logic wr_epc;

    //////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////

    always_comb
    begin
        wr_count   = wr.we && (wr.addr == `CP0_REG_COUNT);
        wr_compare = wr.we && (wr.addr == `CP0_REG_COMPARE);
        wr_status  = wr.we && (wr.addr == `CP0_REG_STATUS);
        wr_cause   = wr.we && (wr.addr == `CP0_REG_CAUSE);
        wr_epc     = wr.we && (wr.addr == `CP0_REG_EPC);
    end

    //////////////////////////////////////////////////
    // count and timer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= `CP0_RESET_WORD;
        end
        else if (wr_count)
        begin
            count <= wr.data; // reload
        end
        else
        begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            compare   <= `CP0_RESET_WORD;
            timer_int <= 1'b0;
        end
        else
        begin
            // zero compare disables the timer
            if (compare != '0 && count == compare)
            begin
                timer_int <= 1'b1;
            end

            // a compare write acks the timer, and beats a match
            if (wr_compare)
            begin
                compare   <= wr.data;
                timer_int <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // status
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status_sw <= `CP0_RESET_WORD;
            exl       <= 1'b0;
        end
        else
        begin
            if (wr_status)
            begin
                status_sw <= wr.data & `STATUS_WMASK;
            end

            // exl is hardware only
            if (commit.take)
            begin
                exl <= 1'b1;
            end
            else if (commit.eret)
            begin
                exl <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // cause
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cause_sw <= `CP0_RESET_WORD;
            hw_ip    <= '0;
            bd       <= 1'b0;
            exc_code <= '0;
        end
        else
        begin
            hw_ip <= {hw_int[5] | timer_int, hw_int[4:0]}; // timer shares ip7

            if (wr_cause)
            begin
                cause_sw <= wr.data & `CAUSE_WMASK;
            end

            if (commit.take)
            begin
                exc_code <= commit.code;
                if (!exl)
                begin
                    bd <= commit.bd; // nested exceptions keep bd
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // epc
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            epc <= `CP0_RESET_WORD;
        end
        else if (commit.take && !exl)
        begin
            epc <= commit.pc; // commit beats mtc0
        end
        else if (wr_epc)
        begin
            epc <= wr.data;
        end
    end

    // architectural views
    assign status = status_sw | {30'b0, exl, 1'b0};
    assign cause  = cause_sw | {bd, 15'b0, hw_ip, 3'b0, exc_code, 2'b00};

    //////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////

    always_comb
    begin
        case (rd_addr)
            `CP0_REG_COUNT:   rd_data = count;
            `CP0_REG_COMPARE: rd_data = compare;
            `CP0_REG_STATUS:  rd_data = status;
            `CP0_REG_CAUSE:   rd_data = cause;
            `CP0_REG_EPC:     rd_data = epc;
            `CP0_REG_PRID:    rd_data = `PRID_VALUE;
            `CP0_REG_CONFIG:  rd_data = `CONFIG_VALUE;
            default:          rd_data = '0; // unimplemented
        endcase
    end

endmodule

// ==== logic/cp0_exception_unit.sv ====
`timescale 1ns/1ns

`include "mips_cp0_config.svh"

module cp0_exception_unit (
    input  cp0_pkg::exc_req_t     req,
    input  cp0_pkg::cp0_word_t    status,
    input  cp0_pkg::cp0_word_t    cause,
    input  cp0_pkg::cp0_word_t    epc,
    output cp0_pkg::exc_commit_t  commit,
    output cp0_pkg::redirect_t    redirect
);
    import cp0_pkg::*;

    logic       st_ie;
    logic       st_exl;
    logic       st_bev;
    logic [7:0] st_im;
    logic [7:0] ca_ip;

    logic       int_pending;
    logic       exc_any;
    exc_code_t  exc_code;
    logic       eret_ok;
    cp0_word_t  exc_vector;
    cp0_word_t  epc_value;

    //////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////

    always_comb
    begin
        st_ie  = status[0];
        st_exl = status[1];
        st_bev = status[22];
        st_im  = status[15:8];
        ca_ip  = cause[15:8];
    end

    // masked ip, globally enabled, not already in a handler
    assign int_pending = (|(ca_ip & st_im)) && st_ie && !st_exl;

    //////////////////////////////////////////////////
    // priority select
    //////////////////////////////////////////////////

    always_comb
    begin
        exc_any  = 1'b1;
        exc_code = `CODE_INT;

        if (!req.valid)
        begin
            exc_any = 1'b0; // flags of a bubble are ignored
        end
        else if (int_pending)
        begin
            exc_code = `CODE_INT;
        end
        else if (req.illegal)
        begin
            exc_code = `CODE_RI;
        end
        else if (req.overflow)
        begin
            exc_code = `CODE_OVF;
        end
        else if (req.trap)
        begin
            exc_code = `CODE_TRAP;
        end
        else if (req.syscall)
        begin
            exc_code = `CODE_SYS;
        end
        else
        begin
            exc_any = 1'b0;
        end
    end

    // eret only when nothing outranks it
    assign eret_ok = req.valid && req.eret && !exc_any;

    //////////////////////////////////////////////////
    // epc value and vector
    //////////////////////////////////////////////////

    // delay slot restarts at the branch
    assign epc_value  = req.in_delay_slot ? (req.pc - 32'd4) : req.pc;
    assign exc_vector = st_bev ? `EXC_VECTOR_BOOT : `EXC_VECTOR_NORMAL;

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    always_comb
    begin
        commit.take = exc_any;
        commit.eret = eret_ok;
        commit.code = exc_code;
        commit.bd   = req.in_delay_slot;
        commit.pc   = epc_value;
    end

    always_comb
    begin
        redirect.flush = exc_any || eret_ok;
        if (exc_any)
        begin
            redirect.target = exc_vector;
        end
        else if (eret_ok)
        begin
            redirect.target = epc; // return from handler
        end
        else
        begin
            redirect.target = '0;
        end
    end

endmodule

// ==== logic/cp0_top.sv ====
`timescale 1ns/1ns

module cp0_top (
    input  logic                clk,
    input  logic                rst_n,

    // pipeline side
    input  cp0_pkg::cp0_wr_t    wr,
    input  cp0_pkg::cp0_addr_t  rd_addr,
    output cp0_pkg::cp0_word_t  rd_data,
    input  logic [5:0]          hw_int,
    input  cp0_pkg::exc_req_t   req,
    output cp0_pkg::redirect_t  redirect,
    output logic                timer_int,

    // register views for forwarding
    output cp0_pkg::cp0_word_t  status,
    output cp0_pkg::cp0_word_t  cause,
    output cp0_pkg::cp0_word_t  epc
);
    import cp0_pkg::*;

    exc_commit_t commit; // exception unit to register file

    //////////////////////////////////////////////////
    // register file and timer
    //////////////////////////////////////////////////

    cp0_regs i_cp0_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .hw_int    (hw_int),
        .commit    (commit),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .timer_int (timer_int)
    );

    //////////////////////////////////////////////////
    // exception select and redirect
    //////////////////////////////////////////////////

    cp0_exception_unit i_cp0_exception_unit (
        .req      (req),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .commit   (commit),
        .redirect (redirect)
    );

endmodule

// ==== testbench/cp0_properties.sv ====
`timescale 1ns/1ns

`include "mips_cp0_config.svh"

module cp0_properties (
    input logic                 clk,
    input logic                 rst_n,
    input cp0_pkg::cp0_wr_t     wr,
    input cp0_pkg::cp0_addr_t   rd_addr,
    input cp0_pkg::cp0_word_t   rd_data,
    input cp0_pkg::exc_req_t    req,
    input cp0_pkg::redirect_t   redirect,
    input cp0_pkg::exc_commit_t commit,
    input cp0_pkg::cp0_word_t   status,
    input logic                 timer_int
);

    int fail_count; // failed properties so far

    // a bubble never flushes
    flush_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.flush |-> req.valid)
        else
        begin
            fail_count++;
            $error("flush raised without a valid instruction");
        end

    exl_after_take: assert property (@(posedge clk) disable iff (!rst_n)
        commit.take |=> status[1]) // exl is bit 1
        else
        begin
            fail_count++;
            $error("exl not set after a taken exception");
        end

    // compare write acks the timer
    timer_clear_on_compare: assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we && wr.addr == `CP0_REG_COMPARE) |=> !timer_int)
        else
        begin
            fail_count++;
            $error("timer_int still high after a compare write");
        end

    prid_constant: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_addr == `CP0_REG_PRID) |-> (rd_data == `PRID_VALUE))
        else
        begin
            fail_count++;
            $error("prid read returned a changed value");
        end

endmodule

bind cp0_top cp0_properties i_cp0_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .req       (req),
    .redirect  (redirect),
    .commit    (commit),
    .status    (status),
    .timer_int (timer_int)
);

// ==== testbench/cp0_tb.sv ====
`timescale 1ns/1ns

`include "mips_cp0_config.svh"

module cp0_tb;
    import cp0_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int REG_CYCLES   = 300;
    localparam int TIMER_CYCLES = 80;
    localparam int MIX_CYCLES   = 400;
    localparam int INT_CYCLES   = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + REG_CYCLES + TIMER_CYCLES
                                + MIX_CYCLES + INT_CYCLES;
    localparam int TIMEOUT_NS   = TOTAL_CYCLES * 8 + 2000; // 8 ns period plus margin

    // architectural state of the reference model
    typedef struct packed {
        cp0_word_t count;
        cp0_word_t compare;
        cp0_word_t status;
        cp0_word_t cause;
        cp0_word_t epc;
        logic      timer_int;
    } model_t;

    logic       clk;
    logic       rst_n;
    cp0_wr_t    wr;
    cp0_addr_t  rd_addr;
    cp0_word_t  rd_data;
    logic [5:0] hw_int;
    exc_req_t   req;
    redirect_t  redirect;
    logic       timer_int;
    cp0_word_t  status;
    cp0_word_t  cause;
    cp0_word_t  epc;

    model_t model;

    cp0_top i_cp0_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .hw_int    (hw_int),
        .req       (req),
        .redirect  (redirect),
        .timer_int (timer_int),
        .status    (status),
        .cause     (cause),
        .epc       (epc)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic cp0_word_t read_model(input model_t m, input cp0_addr_t a);
        case (a)
            `CP0_REG_COUNT:   return m.count;
            `CP0_REG_COMPARE: return m.compare;
            `CP0_REG_STATUS:  return m.status;
            `CP0_REG_CAUSE:   return m.cause;
            `CP0_REG_EPC:     return m.epc;
            `CP0_REG_PRID:    return `PRID_VALUE;
            `CP0_REG_CONFIG:  return `CONFIG_VALUE;
            default:          return '0;
        endcase
    endfunction

    function automatic model_t ref_step(input model_t m, input cp0_wr_t w,
                                        input logic [5:0] hw, input exc_req_t r,
                                        output redirect_t rdir);
        model_t    n;
        logic      pending;
        logic      take;
        logic      leave;
        exc_code_t code;

        n = m;
        pending = (|(m.cause[15:8] & m.status[15:8])) && m.status[0] && !m.status[1];
        take    = r.valid && (pending || r.illegal || r.overflow || r.trap || r.syscall);
        code    = pending ? `CODE_INT : r.illegal ? `CODE_RI : r.overflow ? `CODE_OVF
                : r.trap ? `CODE_TRAP : `CODE_SYS;
        leave   = r.valid && r.eret && !take; // eret only if nothing outranks it

        rdir.flush  = take || leave;
        rdir.target = take ? (m.status[22] ? `EXC_VECTOR_BOOT : `EXC_VECTOR_NORMAL) : m.epc;

        n.count = (w.we && w.addr == `CP0_REG_COUNT) ? w.data : m.count + 32'd1;
        if (m.compare != '0 && m.count == m.compare)
            n.timer_int = 1'b1;
        if (w.we && w.addr == `CP0_REG_COMPARE)
        begin
            n.compare   = w.data;
            n.timer_int = 1'b0; // write beats a match
        end
        if (w.we && w.addr == `CP0_REG_STATUS)
            n.status = (m.status & ~`STATUS_WMASK) | (w.data & `STATUS_WMASK);
        if (w.we && w.addr == `CP0_REG_CAUSE)
            n.cause = (m.cause & ~`CAUSE_WMASK) | (w.data & `CAUSE_WMASK);
        if (w.we && w.addr == `CP0_REG_EPC)
            n.epc = w.data;
        n.cause[15:10] = {hw[5] | m.timer_int, hw[4:0]}; // ip7 shared with timer
        n.status[1] = take ? 1'b1 : (leave ? 1'b0 : m.status[1]);

        // commit overrides the mtc0 fields it touches
        if (take)
        begin
            n.cause[6:2] = code;
            if (!m.status[1])
            begin
                n.cause[31] = r.in_delay_slot;
                n.epc       = r.in_delay_slot ? r.pc - 32'd4 : r.pc;
            end
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input cp0_word_t exp, input cp0_word_t act);
        if (act !== exp)
            abort_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("ERROR %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic check_redirect(input redirect_t exp, input redirect_t act);
        // target only matters while flushing
        if (act.flush !== exp.flush || (exp.flush && act.target !== exp.target))
            abort_run($sformatf("ERROR %0t redirect expected %b/%h actual %b/%h",
                                $time, exp.flush, exp.target, act.flush, act.target));
    endtask

    // registers right after the edge and combinational outputs mid low phase
    initial
    begin
        redirect_t exp_redirect;
        model_t    next_model;

        model = '0;
        forever
        begin
            @(posedge clk);
            #1;
            check_word("status", model.status, status);
            check_word("cause", model.cause, cause);
            check_word("epc", model.epc, epc);
            check_bit("timer_int", model.timer_int, timer_int);
            @(negedge clk);
            #2;
            next_model = ref_step(model, wr, hw_int, req, exp_redirect);
            check_word("rd_data", read_model(model, rd_addr), rd_data);
            check_redirect(exp_redirect, redirect);
            model = rst_n ? next_model : '0;
        end
    end

    // bound property checker
    initial
    begin
        wait (i_cp0_top.i_cp0_properties.fail_count != 0);
        abort_run("a property in the bound checker failed");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    function automatic cp0_addr_t pick_addr();
        if (($urandom % 4) == 0)
            return 5'($urandom % 32); // any register number at all
        return 5'(9 + $urandom % 8);
    endfunction

    task automatic drive_random(input int wr_pct, input int req_pct, input logic with_int);
        @(negedge clk);
        wr.we             = ($urandom % 100) < wr_pct;
        wr.addr           = pick_addr();
        wr.data           = $urandom;
        rd_addr           = pick_addr();
        req.valid         = ($urandom % 100) < req_pct;
        req.syscall       = ($urandom % 8) == 0;
        req.illegal       = ($urandom % 8) == 0;
        req.trap          = ($urandom % 8) == 0;
        req.overflow      = ($urandom % 8) == 0;
        req.eret          = ($urandom % 2) == 0;
        req.in_delay_slot = ($urandom % 2) == 0;
        req.pc            = $urandom & 32'hffff_fffc;
        hw_int            = with_int ? 6'($urandom) : 6'd0;
    endtask

    task automatic write_reg(input cp0_addr_t addr, input cp0_word_t data);
        @(negedge clk);
        wr.we   = 1'b1;
        wr.addr = addr;
        wr.data = data;
        rd_addr = addr; // old value reads back
        req     = '0;
        hw_int  = '0;
    endtask

    task automatic idle(input int cycles, input logic valid);
        repeat (cycles)
        begin
            @(negedge clk);
            wr.we     = 1'b0;
            rd_addr   = pick_addr();
            req       = '0;
            req.valid = valid;
            req.pc    = $urandom & 32'hffff_fffc;
            hw_int    = '0;
        end
    endtask

    task automatic do_eret();
        @(negedge clk);
        wr.we     = 1'b0;
        req       = '0;
        req.valid = 1'b1;
        req.eret  = 1'b1;
        hw_int    = '0;
    endtask

    initial
    begin
        void'($urandom(32'h86ae));
        rst_n     = 1'b0;
        wr        = '0;
        rd_addr   = '0;
        hw_int    = '0;
        req       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        repeat (REG_CYCLES) drive_random(80, 0, 1'b0); // flags ignored without valid

        // timer match, then ack
        write_reg(`CP0_REG_COMPARE, 32'd40);
        write_reg(`CP0_REG_COUNT, 32'd10);
        idle(40, 1'b0);
        write_reg(`CP0_REG_COMPARE, 32'd0);
        idle(4, 1'b0);

        // timer into the interrupt path through ip7
        write_reg(`CP0_REG_STATUS, 32'h0000_8001);
        write_reg(`CP0_REG_COMPARE, 32'd30);
        write_reg(`CP0_REG_COUNT, 32'd20);
        idle(20, 1'b1);
        write_reg(`CP0_REG_COMPARE, 32'd0);
        do_eret();
        write_reg(`CP0_REG_STATUS, 32'd0);

        repeat (MIX_CYCLES) drive_random(10, 70, 1'b0);
        repeat (INT_CYCLES) drive_random(30, 50, 1'b1); // hw lines and masks
        idle(3, 1'b0);

        $display(">>> PASS");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        abort_run("watchdog timeout, the test sequences did not complete in time");
    end

endmodule

// ==== mips_cp0.f ====
+incdir+include
logic/cp0_pkg.sv
logic/cp0_regs.sv
logic/cp0_exception_unit.sv
logic/cp0_top.sv
testbench/cp0_properties.sv
testbench/cp0_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the CP0 testbench with Verilator and run it.
# The exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cp0_tb -f mips_cp0.f -o cp0_sim \
    && ./obj_dir/cp0_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }
